// ==== hockey_pkg.sv ====
`default_nettype none

package hockey_pkg;

    // puck coordinate and score widths
    localparam int COL_W   = 3;
    localparam int ROW_W   = 3;
    localparam int SCORE_W = 2;

    typedef enum logic [3:0] {
        st_idle,
        st_start,       // short start display
        st_serve_a,
        st_serve_b,
        st_travel_ab,   // puck moving toward B
        st_travel_ba,   // puck moving toward A
        st_resp_b,      // B may return
        st_resp_a,      // A may return
        st_goal_a,      // goal scored by A
        st_goal_b,      // goal scored by B
        st_game_over
    } game_state_t;

    // vertical puck direction, up means increasing row
    typedef enum logic [1:0] {
        dir_hold = 2'd0,
        dir_up   = 2'd1,
        dir_down = 2'd2
    } puck_dir_t;

    // which limit the window timer compares against
    typedef enum logic [1:0] {
        win_start = 2'd0,
        win_resp  = 2'd1,
        win_goal  = 2'd2
    } window_t;

    // active-low segment patterns, index is the digit
    localparam logic [0:3][6:0] SEG_DIGITS = {
        7'b0000001,
        7'b1001111,
        7'b0010010,
        7'b0000110
    };

    localparam logic [6:0] SEG_BLANK = 7'b1111111;

endpackage

`default_nettype wire

// ==== hockey_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hockey_timer import hockey_pkg::*; #(
    parameter int START_CYCLES = 2,
    parameter int RESP_CYCLES  = 50,
    parameter int GOAL_CYCLES  = 50
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    timer_clear,
    input  window_t window,
    output logic    expired
);

    logic [7:0] count;
    logic [7:0] limit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (timer_clear) begin
            count <= '0;    // new state, new window
        end else if (count != 8'hff) begin
            count <= count + 8'd1;  // saturate in untimed states
        end
    end

    always_comb begin
        case (window)
            win_resp: limit = 8'(RESP_CYCLES);
            win_goal: limit = 8'(GOAL_CYCLES);
            default:  limit = 8'(START_CYCLES);
        endcase
    end

    // count starts at 0 on entry, so the window is limit + 1 cycles
    assign expired = (count >= limit);

endmodule

`default_nettype wire

// ==== hockey_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module hockey_fsm import hockey_pkg::*; #(
    parameter int FIELD_LEN  = 5,
    parameter int FIELD_ROWS = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             btn_a,
    input  logic             btn_b,
    input  logic [ROW_W-1:0] row_a,
    input  logic [ROW_W-1:0] row_b,
    input  logic [COL_W-1:0] col,
    input  logic [ROW_W-1:0] row,
    input  logic             expired,
    input  logic             winner_found,
    output game_state_t      state,
    output logic             serve_a,
    output logic             serve_b,
    output logic             goal_a,
    output logic             goal_b,
    output logic             timer_clear,
    output window_t          window
);

    // column seen in the last travel cycle in each direction
    localparam logic [COL_W-1:0] COL_LAST_AB = COL_W'(FIELD_LEN - 2);
    localparam logic [COL_W-1:0] COL_LAST_BA = COL_W'(1);
    localparam logic [ROW_W-1:0] ROW_LIMIT   = ROW_W'(FIELD_ROWS);

    game_state_t state_nxt;
    logic        b_serves;  // first server, picked in idle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            b_serves <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == st_idle) begin
                b_serves <= btn_b;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        serve_a   = 1'b0;
        serve_b   = 1'b0;
        goal_a    = 1'b0;
        goal_b    = 1'b0;
        case (state)
            st_idle: begin
                if (btn_a ^ btn_b) begin    // exactly one player
                    state_nxt = st_start;
                end
            end
            st_start: begin
                if (expired) begin
                    state_nxt = b_serves ? st_serve_b : st_serve_a;
                end
            end
            st_serve_a: begin
                if (btn_a && row_a < ROW_LIMIT) begin
                    serve_a   = 1'b1;
                    state_nxt = st_travel_ab;
                end
            end
            st_serve_b: begin
                if (btn_b && row_b < ROW_LIMIT) begin
                    serve_b   = 1'b1;
                    state_nxt = st_travel_ba;
                end
            end
            st_travel_ab: begin
                if (col == COL_LAST_AB) begin
                    state_nxt = st_resp_b;
                end
            end
            st_travel_ba: begin
                if (col == COL_LAST_BA) begin
                    state_nxt = st_resp_a;
                end
            end
            st_resp_b: begin
                if (btn_b && row_b == row) begin
                    state_nxt = st_travel_ba;   // good return
                end else if (btn_b || expired) begin
                    goal_a    = 1'b1;
                    state_nxt = st_goal_a;
                end
            end
            st_resp_a: begin
                if (btn_a && row_a == row) begin
                    state_nxt = st_travel_ab;
                end else if (btn_a || expired) begin
                    goal_b    = 1'b1;
                    state_nxt = st_goal_b;
                end
            end
            st_goal_a: begin
                if (expired) begin
                    // B conceded, so B serves
                    state_nxt = winner_found ? st_game_over : st_serve_b;
                end
            end
            st_goal_b: begin
                if (expired) begin
                    state_nxt = winner_found ? st_game_over : st_serve_a;
                end
            end
            st_game_over: state_nxt = st_game_over;  // only reset leaves
            default:      state_nxt = st_idle;
        endcase
    end

    // restart the count on every state change
    assign timer_clear = (state_nxt != state);

    always_comb begin
        case (state)
            st_resp_a, st_resp_b: window = win_resp;
            st_goal_a, st_goal_b: window = win_goal;
            default:              window = win_start;
        endcase
    end

endmodule

`default_nettype wire

// ==== puck_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module puck_tracker import hockey_pkg::*; #(
    parameter int FIELD_LEN  = 5,
    parameter int FIELD_ROWS = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  game_state_t      state,
    input  logic             serve_a,
    input  logic             serve_b,
    input  logic [ROW_W-1:0] row_a,
    input  logic [ROW_W-1:0] row_b,
    input  logic [1:0]       dir_a,
    input  logic [1:0]       dir_b,
    output logic [COL_W-1:0] col,
    output logic [ROW_W-1:0] row
);

    localparam logic [COL_W-1:0] COL_B   = COL_W'(FIELD_LEN - 1);
    localparam logic [ROW_W-1:0] ROW_TOP = ROW_W'(FIELD_ROWS - 1);

    puck_dir_t dir;

    // switch value 3 has no meaning, treat it as no vertical motion
    function automatic puck_dir_t sw_to_dir(input logic [1:0] sw);
        case (sw)
            2'd1:    return dir_up;
            2'd2:    return dir_down;
            default: return dir_hold;
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            col <= '0;
            row <= '0;
            dir <= dir_hold;
        end else if (serve_a) begin
            col <= '0;
            row <= row_a;
            dir <= sw_to_dir(dir_a);
        end else if (serve_b) begin
            col <= COL_B;
            row <= row_b;
            dir <= sw_to_dir(dir_b);
        end else if (state == st_travel_ab || state == st_travel_ba) begin
            if (state == st_travel_ab) begin
                col <= col + COL_W'(1);
            end else begin
                col <= col - COL_W'(1);
            end
            // bounce: flip at the wall and hold the row one cycle
            case (dir)
                dir_up: begin
                    if (row == ROW_TOP) begin
                        dir <= dir_down;
                    end else begin
                        row <= row + ROW_W'(1);
                    end
                end
                dir_down: begin
                    if (row == '0) begin
                        dir <= dir_up;
                    end else begin
                        row <= row - ROW_W'(1);
                    end
                end
                default: ;  // hold, straight shot
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== score_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_keeper import hockey_pkg::*; #(
    parameter int WIN_SCORE = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               goal_a,
    input  logic               goal_b,
    output logic [SCORE_W-1:0] score_a,
    output logic [SCORE_W-1:0] score_b,
    output logic               winner_found
);

    localparam logic [SCORE_W-1:0] WIN_VAL = SCORE_W'(WIN_SCORE);

    logic a_won;
    logic b_won;

    assign a_won = (score_a == WIN_VAL);
    assign b_won = (score_b == WIN_VAL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            score_a <= '0;
            score_b <= '0;
        end else begin
            // no counting past a finished game
            if (goal_a && !a_won && !b_won) begin
                score_a <= score_a + SCORE_W'(1);
            end
            if (goal_b && !a_won && !b_won) begin
                score_b <= score_b + SCORE_W'(1);
            end
        end
    end

    // visible in the first goal cycle
    assign winner_found = a_won | b_won;

endmodule

`default_nettype wire

// ==== hockey_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module hockey_display import hockey_pkg::*; (
    input  game_state_t        state,
    input  logic [COL_W-1:0]   col,
    input  logic [SCORE_W-1:0] score_a,
    input  logic [SCORE_W-1:0] score_b,
    output logic               led_a,
    output logic               led_b,
    output logic [4:0]         led_x,
    output logic [6:0]         ssd_a,
    output logic [6:0]         ssd_b
);

    logic show_score;

    always_comb begin
        led_a = 1'b0;
        led_b = 1'b0;
        led_x = 5'b00000;
        case (state)
            st_idle: begin
                led_a = 1'b1;   // both may start
                led_b = 1'b1;
            end
            st_start, st_goal_a, st_goal_b: begin
                led_x = 5'b11111;
            end
            st_serve_a, st_resp_a: begin
                led_a = 1'b1;
            end
            st_serve_b, st_resp_b: begin
                led_b = 1'b1;
            end
            st_travel_ab, st_travel_ba: begin
                led_x = 5'b00001 << col;    // puck position
            end
            st_game_over: begin
                led_x = 5'b10101;
            end
            default: ;
        endcase
    end

    // scores only shown while the field is not in play
    always_comb begin
        case (state)
            st_start, st_goal_a, st_goal_b, st_game_over: show_score = 1'b1;
            default:                                       show_score = 1'b0;
        endcase
    end

    assign ssd_a = show_score ? SEG_DIGITS[score_a] : SEG_BLANK;
    assign ssd_b = show_score ? SEG_DIGITS[score_b] : SEG_BLANK;

endmodule

`default_nettype wire

// ==== hockey_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hockey_top import hockey_pkg::*; #(
    parameter int FIELD_LEN    = 5,
    parameter int FIELD_ROWS   = 5,
    parameter int WIN_SCORE    = 3,
    parameter int START_CYCLES = 2,
    parameter int RESP_CYCLES  = 50,
    parameter int GOAL_CYCLES  = 50
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             btn_a,
    input  logic             btn_b,
    input  logic [ROW_W-1:0] row_a,
    input  logic [ROW_W-1:0] row_b,
    input  logic [1:0]       dir_a,
    input  logic [1:0]       dir_b,
    output logic             led_a,
    output logic             led_b,
    output logic [4:0]       led_x,
    output logic [6:0]       ssd_a,
    output logic [6:0]       ssd_b
);

    game_state_t        state;
    window_t            window;
    logic               serve_a;
    logic               serve_b;
    logic               goal_a;
    logic               goal_b;
    logic               timer_clear;
    logic               expired;
    logic               winner_found;
    logic [COL_W-1:0]   col;
    logic [ROW_W-1:0]   row;
    logic [SCORE_W-1:0] score_a;
    logic [SCORE_W-1:0] score_b;

    hockey_fsm #(
        .FIELD_LEN (FIELD_LEN),
        .FIELD_ROWS(FIELD_ROWS)
    ) u_fsm (
        .clk(clk), .rst(rst),
        .btn_a(btn_a), .btn_b(btn_b),
        .row_a(row_a), .row_b(row_b),
        .col(col), .row(row),
        .expired(expired), .winner_found(winner_found),
        .state(state),
        .serve_a(serve_a), .serve_b(serve_b),
        .goal_a(goal_a), .goal_b(goal_b),
        .timer_clear(timer_clear), .window(window)
    );

    hockey_timer #(
        .START_CYCLES(START_CYCLES),
        .RESP_CYCLES (RESP_CYCLES),
        .GOAL_CYCLES (GOAL_CYCLES)
    ) u_timer (
        .clk(clk), .rst(rst),
        .timer_clear(timer_clear), .window(window),
        .expired(expired)
    );

    puck_tracker #(
        .FIELD_LEN (FIELD_LEN),
        .FIELD_ROWS(FIELD_ROWS)
    ) u_puck (
        .clk(clk), .rst(rst), .state(state),
        .serve_a(serve_a), .serve_b(serve_b),
        .row_a(row_a), .row_b(row_b),
        .dir_a(dir_a), .dir_b(dir_b),
        .col(col), .row(row)
    );

    score_keeper #(
        .WIN_SCORE(WIN_SCORE)
    ) u_score (
        .clk(clk), .rst(rst),
        .goal_a(goal_a), .goal_b(goal_b),
        .score_a(score_a), .score_b(score_b),
        .winner_found(winner_found)
    );

    hockey_display u_display (
        .state(state), .col(col),
        .score_a(score_a), .score_b(score_b),
        .led_a(led_a), .led_b(led_b), .led_x(led_x),
        .ssd_a(ssd_a), .ssd_b(ssd_b)
    );

endmodule

`default_nettype wire

// ==== tb_hockey.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hockey;

    localparam int START_CYC = 2;
    localparam int RESP_CYC  = 8;
    localparam int GOAL_CYC  = 4;
    localparam int FIELD_LEN = 5;
    localparam int WIN_SCORE = 3;
    localparam int MAX_LINES = 32;

    logic       clk;
    logic       rst;
    logic       btn_a;
    logic       btn_b;
    logic [2:0] row_a;
    logic [2:0] row_b;
    logic [1:0] dir_a;
    logic [1:0] dir_b;
    logic       led_a;
    logic       led_b;
    logic [4:0] led_x;
    logic [6:0] ssd_a;
    logic [6:0] ssd_b;

    logic [7:0] vec_mem [0:MAX_LINES*7-1];  // seven fields per line
    logic [6:0] seg_tab [0:3];
    logic [2:0] pred_row;   // expected puck row at the receiver
    logic [1:0] pred_dir;
    string      tname;
    int         seed;
    int         n_errors;
    int         n_pass;
    int         n_fail;
    int         n_lines;
    int         cycle_count = 0;
    int         cycle_limit = 1000;

    hockey_top #(
        .RESP_CYCLES(RESP_CYC),
        .GOAL_CYCLES(GOAL_CYC)
    ) u_hockey_top (
        .clk(clk), .rst(rst),
        .btn_a(btn_a), .btn_b(btn_b),
        .row_a(row_a), .row_b(row_b),
        .dir_a(dir_a), .dir_b(dir_b),
        .led_a(led_a), .led_b(led_b), .led_x(led_x),
        .ssd_a(ssd_a), .ssd_b(ssd_b)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run stopped after %0d cycles, the game did not move on", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input logic [6:0] exp_v,
                                   input logic [6:0] act_v);
        $display("** Error %s %s: expected %b, actual %b", tname, what, exp_v, act_v);
        n_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s %s", tname, msg);
        n_errors++;
    endtask

    // one travel cycle of the bounce rule
    task automatic step_puck();
        case (pred_dir)
            2'd1: begin
                if (pred_row == 3'd4) begin
                    pred_dir = 2'd2;    // top wall, row holds
                end else begin
                    pred_row = pred_row + 3'd1;
                end
            end
            2'd2: begin
                if (pred_row == 3'd0) begin
                    pred_dir = 2'd1;
                end else begin
                    pred_row = pred_row - 3'd1;
                end
            end
            default: ;
        endcase
    endtask

    task automatic wait_leds(input logic ea, input logic eb, input logic [4:0] ex,
                             input int max_cyc, input string what);
        int n;
        n = 0;
        while ((led_a !== ea || led_b !== eb || led_x !== ex) && n < max_cyc) begin
            @(negedge clk);
            n++;
        end
        if (led_a !== ea || led_b !== eb || led_x !== ex) begin
            report_failure($sformatf("never showed %s within %0d cycles", what, max_cyc));
        end
    endtask

    task automatic check_scores(input logic [7:0] ea, input logic [7:0] eb);
        if (ssd_a != seg_tab[ea[1:0]]) report_mismatch("ssd_a", seg_tab[ea[1:0]], ssd_a);
        if (ssd_b != seg_tab[eb[1:0]]) report_mismatch("ssd_b", seg_tab[eb[1:0]], ssd_b);
    endtask

    task automatic check_travel(input logic to_b);
        int k;
        logic [4:0] exp_x;
        for (k = 0; k < FIELD_LEN - 1; k++) begin
            exp_x = to_b ? (5'b00001 << k) : (5'b10000 >> k);
            if (led_x != exp_x) report_mismatch("led_x", {2'b00, exp_x}, {2'b00, led_x});
            if (ssd_a != 7'h7f) report_mismatch("ssd_a blank", 7'h7f, ssd_a);
            if (ssd_b != 7'h7f) report_mismatch("ssd_b blank", 7'h7f, ssd_b);
            step_puck();
            @(negedge clk);
        end
        // receiver window open
        if (led_b != to_b) report_mismatch("led_b", {6'b0, to_b}, {6'b0, led_b});
        if (led_a != !to_b) report_mismatch("led_a", {6'b0, !to_b}, {6'b0, led_a});
        if (led_x != 5'b00000) report_mismatch("led_x", 7'h00, {2'b00, led_x});
    endtask

    task automatic press(input logic [7:0] who, input logic [2:0] r, input logic [1:0] d);
        btn_a = (who == 8'd1 || who == 8'd3);
        btn_b = (who == 8'd2 || who == 8'd3);
        if (who == 8'd1) begin
            row_a = r;
            dir_a = d;
        end else if (who == 8'd2) begin
            row_b = r;
            dir_b = d;
        end
    endtask

    task automatic release_buttons();
        btn_a = 1'b0;
        btn_b = 1'b0;
    endtask

    // goal window, then either the next serve or the end of the game
    task automatic finish_goal(input logic [7:0] who, input logic [7:0] ea,
                               input logic [7:0] eb);
        int k;
        check_scores(ea, eb);
        if (ea == 8'(WIN_SCORE) || eb == 8'(WIN_SCORE)) begin
            wait_leds(1'b0, 1'b0, 5'b10101, GOAL_CYC + 3, "the game over pattern");
            for (k = 0; k < 10; k++) begin
                btn_a = k[0];     // buttons must change nothing now
                btn_b = k[1];
                @(negedge clk);
                if (led_x != 5'b10101) report_mismatch("led_x held", 7'h15, {2'b00, led_x});
                check_scores(ea, eb);
            end
            release_buttons();
        end else begin
            wait_leds(who == 8'd1, who == 8'd2, 5'b00000, GOAL_CYC + 3,
                      "the conceding player's serve");
        end
    endtask

    // idle outputs after a reset out of game over, then cleared scores
    task automatic check_reset_idle();
        int errs;
        errs = n_errors;
        if (led_a !== 1'b1) report_mismatch("led_a", 7'h01, {6'b0, led_a});
        if (led_b !== 1'b1) report_mismatch("led_b", 7'h01, {6'b0, led_b});
        if (led_x !== 5'b00000) report_mismatch("led_x", 7'h00, {2'b00, led_x});
        if (ssd_a !== 7'h7f) report_mismatch("ssd_a", 7'h7f, ssd_a);
        if (ssd_b !== 7'h7f) report_mismatch("ssd_b", 7'h7f, ssd_b);
        btn_a = 1'b1;   // scores only show in the start window
        @(negedge clk);
        release_buttons();
        check_scores(8'd0, 8'd0);
        if (n_errors == errs) begin
            n_pass++;
            $display("%s reset: pass", tname);
        end else begin
            n_fail++;
            $display("%s reset: fail", tname);
        end
    endtask

    task automatic run_step(input int idx);
        int          base;
        int          errs;
        logic [7:0]  act;
        logic [7:0]  who;
        logic [2:0]  r;
        logic [1:0]  d;
        logic [7:0]  ea;
        logic [7:0]  eb;
        logic [31:0] rnd;
        string       act_name;
        base  = idx * 7;
        tname = $sformatf("t%02h", vec_mem[base]);
        act   = vec_mem[base + 1];
        who   = vec_mem[base + 2];
        r     = vec_mem[base + 3][2:0];
        d     = vec_mem[base + 4][1:0];
        ea    = vec_mem[base + 5];
        eb    = vec_mem[base + 6];
        errs  = n_errors;
        act_name = "unknown";
        case (act)
            8'd0: begin
                act_name = "idle press";
                rnd = $random(seed);
                row_a = rnd[2:0];
                row_b = rnd[5:3];
                btn_a = (who == 8'd1 || who == 8'd3);
                btn_b = (who == 8'd2 || who == 8'd3);
                @(negedge clk);
                release_buttons();
                if (who == 8'd1 || who == 8'd2) begin
                    if (led_x != 5'b11111) report_mismatch("led_x", 7'h1f, {2'b00, led_x});
                    check_scores(ea, eb);
                    wait_leds(who == 8'd1, who == 8'd2, 5'b00000, START_CYC + 3, "the serve");
                end else begin
                    if (led_a != 1'b1) report_mismatch("led_a", 7'h01, {6'b0, led_a});
                    if (led_b != 1'b1) report_mismatch("led_b", 7'h01, {6'b0, led_b});
                    if (ssd_a != 7'h7f) report_mismatch("ssd_a", 7'h7f, ssd_a);
                end
            end
            8'd1: begin
                act_name = "serve";
                press(who, r, d);
                pred_row = r;
                pred_dir = (d == 2'd3) ? 2'd0 : d;  // 3 acts as hold
                @(negedge clk);
                release_buttons();
                check_travel(who == 8'd1);
            end
            8'd2: begin
                act_name = "return";
                press(who, pred_row, 2'd0);
                @(negedge clk);
                release_buttons();
                check_travel(who == 8'd1);
            end
            8'd3: begin
                act_name = "miss";
                wait_leds(1'b0, 1'b0, 5'b11111, RESP_CYC + 3, "the goal");
                finish_goal(who, ea, eb);
            end
            8'd4: begin
                act_name = "wrong row";
                press(who, (pred_row == 3'd4) ? 3'd0 : pred_row + 3'd1, 2'd0);
                @(negedge clk);
                release_buttons();
                if (led_x != 5'b11111) report_mismatch("led_x", 7'h1f, {2'b00, led_x});
                finish_goal(who, ea, eb);
            end
            default: report_failure("has an unknown action in the vector file");
        endcase
        if (n_errors == errs) begin
            n_pass++;
            $display("%s %s: pass", tname, act_name);
        end else begin
            n_fail++;
            $display("%s %s: fail", tname, act_name);
        end
    endtask

    initial begin
        seed = 56;
        clk = 1'b0;
        rst = 1'b1;
        release_buttons();
        row_a = 3'd0;
        row_b = 3'd0;
        dir_a = 2'd0;
        dir_b = 2'd0;
        n_errors = 0;
        n_pass = 0;
        n_fail = 0;
        tname = "setup";
        seg_tab[0] = 7'b0000001;
        seg_tab[1] = 7'b1001111;
        seg_tab[2] = 7'b0010010;
        seg_tab[3] = 7'b0000110;
        for (int i = 0; i < MAX_LINES * 7; i++) begin
            vec_mem[i] = 8'hff;     // marks the end of the file
        end
        $readmemh("hockey_vectors.txt", vec_mem);
        n_lines = 0;
        while (n_lines < MAX_LINES && vec_mem[n_lines * 7] != 8'hff) begin
            n_lines++;
        end
        if (n_lines == 0) report_failure("found no test vectors");
        cycle_limit = n_lines * (START_CYC + FIELD_LEN - 1 + RESP_CYC + GOAL_CYC + 10) + 20;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_lines; i++) begin
            run_step(i);
        end
        // reset leaves game over
        tname = "t_reset";
        rst = 1'b1;
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_idle();
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_pass + n_fail, n_pass, n_fail, n_errors);
        if (n_errors == 0 && n_fail == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hockey_vectors.txt ====
// name action player row dir score_a score_b
// action 0 idle press, 1 serve, 2 return, 3 miss, 4 wrong row; player 1 A, 2 B, 0 none, 3 both
01 0 0 0 0 0 0  // no button, stays idle
02 0 3 0 0 0 0  // both buttons, stays idle
03 0 2 0 0 0 0  // B takes the serve
04 1 2 1 2 0 0  // B serves row 1 down, bounces at row 0
05 2 1 0 0 0 0  // A returns on the predicted row
06 3 2 0 0 1 0  // B lets the window run out
07 1 2 3 1 1 0  // B serves row 3 up
08 4 1 0 0 1 1  // A guesses the wrong row
09 1 1 3 1 1 1  // A serves row 3 up, bounces at row 4
0a 2 2 0 0 1 1  // B returns
0b 2 1 0 0 1 1  // A returns
0c 3 2 0 0 2 1  // B misses
0d 1 2 0 3 2 1  // switch value 3 is a straight shot
0e 2 1 0 0 2 1  // A returns
0f 4 2 0 0 3 1  // third goal for A ends the game

// ==== all.f ====
hockey_pkg.sv
hockey_timer.sv
hockey_fsm.sv
puck_tracker.sv
score_keeper.sv
hockey_display.sv
hockey_top.sv
tb_hockey.sv

// ==== Makefile ====
# Verilator build and run for the air-hockey testbench

TOP = tb_hockey

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
